//--- tb.f
src/bitpack_pkg.sv
src/bitfifo_if.sv
src/bit_fifo.sv
src/pack_ctrl.sv
src/word_out_stage.sv
src/pack_counters.sv
src/bit_packer_top.sv
verif/tb_bit_packer.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_bit_packer -f tb.f -o sim_bit_packer \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_bit_packer > sim.log 2>&1 || { cat sim.log; echo "simulator error"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "run ended without a result"; exit 1; }
echo "test passed"

//--- verif/tb_bit_packer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bit_packer;
   import bitpack_pkg::*;

   typedef struct {
      string             name;
      pack_op_t          op;
      logic [CODE_W-1:0] code;
      logic [LEN_W-1:0]  len;
      int                stall;
      int                min_lat;
   } row_t;

   logic              clk;
   logic              reset;
   logic              in_req;
   pack_op_t          in_op;
   logic [CODE_W-1:0] in_code;
   logic [LEN_W-1:0]  in_len;
   logic              in_ack;
   logic              out_req;
   logic [WORD_W-1:0] out_word;
   logic              out_ack;
   logic [CNT_W-1:0]  bit_count;
   logic [CNT_W-1:0]  word_count;

   row_t              rows[$];
   logic [WORD_W-1:0] exp_q[$];
   logic [WORD_W-1:0] acc;
   logic [15:0]       lfsr_state = 16'd17;
   int                nacc;
   int                nwords;
   int                nrecv;
   int                bit_sum;
   int                errors;
   int                checks;
   int                row_cnt;
   int                cur_stall;

   bit_packer_top i_bit_packer_top (
      .clk_i       (clk),
      .reset_i     (reset),
      .in_req_i    (in_req),
      .in_op_i     (in_op),
      .in_code_i   (in_code),
      .in_len_i    (in_len),
      .in_ack_o    (in_ack),
      .out_req_o   (out_req),
      .out_word_o  (out_word),
      .out_ack_i   (out_ack),
      .bit_count_o (bit_count),
      .word_count_o(word_count)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // galois lfsr stepped once per bit taken
   function automatic logic lfsr_step();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b) begin
         lfsr_state = lfsr_state ^ 16'hB400;
      end
      return b;
   endfunction

   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], lfsr_step()};
      end
      return v;
   endfunction

   // outputs are sampled and inputs driven 1 ns after the edge
   task automatic step();
      @(posedge clk);
      #1;
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic add_row(input string name, input pack_op_t op, input logic [15:0] code,
                          input logic [4:0] len, input int stall, input int min_lat);
      row_t r;
      r.name    = name;
      r.op      = op;
      r.code    = code;
      r.len     = len;
      r.stall   = stall;
      r.min_lat = min_lat;
      rows.push_back(r);
   endtask

   // push rows with len 0 take a random code and length
   task automatic build_table();
      logic [15:0] pat;
      pat = 16'hA5C3;
      for (int i = 0; i < 16; i++) begin
         add_row($sformatf("one_bit_%0d", i), OP_PUSH, {15'h7FFF, pat[15-i]}, 5'd1, 0, 0);
      end
      add_row("mix_3", OP_PUSH, 16'hFFF5, 5'd3, 0, 0);
      add_row("mix_7", OP_PUSH, 16'h8A5C, 5'd7, 0, 0);
      add_row("mix_13", OP_PUSH, 16'hF234, 5'd13, 0, 0);
      add_row("mix_16", OP_PUSH, 16'hBEEF, 5'd16, 0, 0);
      add_row("mix_5", OP_PUSH, 16'hFF91, 5'd5, 0, 0);
      add_row("flush_partial", OP_FLUSH, 16'h0, 5'd0, 0, 0);
      add_row("flush_empty", OP_FLUSH, 16'h0, 5'd0, 0, 0);
      for (int i = 0; i < 10; i++) begin
         add_row($sformatf("random_%0d", i), OP_PUSH, 16'h0, 5'd0, 0, 0);
      end
      add_row("flush_random", OP_FLUSH, 16'h0, 5'd0, 0, 0);
      // first word stalls so the third push has to wait for it
      add_row("stall_fill_a", OP_PUSH, 16'h1111, 5'd16, 60, 0);
      add_row("stall_fill_b", OP_PUSH, 16'h2222, 5'd16, 60, 0);
      add_row("stall_hold", OP_PUSH, 16'h3333, 5'd16, 60, 40);
      add_row("flush_end", OP_FLUSH, 16'h0, 5'd0, 0, 0);
   endtask

   // msb-first bit stream cut into words
   task automatic append_code(input logic [15:0] code, input logic [4:0] len);
      for (int i = int'(len) - 1; i >= 0; i--) begin
         acc = {acc[14:0], code[i]};
         nacc++;
         if (nacc == WORD_W) begin
            exp_q.push_back(acc);
            nwords++;
            nacc = 0;
         end
      end
   endtask

   task automatic pad_flush();
      logic [WORD_W-1:0] w;
      if (nacc != 0) begin
         w = acc << (WORD_W - nacc);
         exp_q.push_back(w);
         nwords++;
         nacc = 0;
      end
   endtask

   task automatic send(input pack_op_t op, input logic [15:0] code, input logic [4:0] len,
                       output int lat);
      in_op   = op;
      in_code = code;
      in_len  = len;
      in_req  = 1'b1;
      lat     = 0;
      while (!in_ack) begin
         step();
         lat++;
      end
      in_req = 1'b0;
      while (in_ack) begin
         step();
      end
   endtask

   // output consumer with random or forced ack delays
   initial begin
      logic [WORD_W-1:0] w;
      int delay;
      out_ack = 1'b0;
      @(negedge reset);
      forever begin
         step();
         if (out_req) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("output word %h arrived while no word was expected", out_word);
            end else begin
               w = exp_q.pop_front();
               check($sformatf("word_%0d", nrecv), w, out_word);
            end
            nrecv++;
            delay = (cur_stall != 0) ? cur_stall : int'(rand_bits(2));
            repeat (delay) step();
            out_ack = 1'b1;
            while (out_req) begin
               step();
            end
            out_ack = 1'b0;
         end
      end
   end

   initial begin
      wait (row_cnt != 0);
      repeat ((row_cnt + 2) * 200) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", (row_cnt + 2) * 200);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      int   lat;
      row_t r;
      reset   = 1'b1;
      in_req  = 1'b0;
      in_op   = OP_PUSH;
      in_code = '0;
      in_len  = '0;
      acc     = '0;
      build_table();
      row_cnt = rows.size();
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      check("reset_in_ack", 0, in_ack);
      check("reset_out_req", 0, out_req);
      check("reset_bit_count", 0, bit_count);
      check("reset_word_count", 0, word_count);
      $display("test reset_state done, errors %0d", errors);
      foreach (rows[k]) begin
         r = rows[k];
         if (r.op == OP_PUSH && r.len == 0) begin
            r.len  = 5'(rand_bits(4)) + 5'd1;
            r.code = rand_bits(16);
         end
         cur_stall = r.stall;
         if (r.op == OP_FLUSH) begin
            pad_flush();
         end else begin
            append_code(r.code, r.len);
            bit_sum += int'(r.len);
         end
         send(r.op, r.code, r.len, lat);
         if (lat < r.min_lat) begin
            check({r.name, "_latency"}, r.min_lat, lat);
         end
         $display("test %s done after %0d cycles, errors %0d", r.name, lat, errors);
      end
      cur_stall = 0;
      // let the consumer take every outstanding word
      while (exp_q.size() != 0 || out_req || out_ack) begin
         step();
      end
      check("bit_count", bit_sum, bit_count);
      check("word_count", nwords, word_count);
      $display("test final_counts done, errors %0d", errors);
      $display("%0d tests, %0d checks, %0d errors", row_cnt + 2, checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src/bit_packer_top.sv
`timescale 1ns/1ps
`default_nettype none

module bit_packer_top (
   input wire                              clk_i,
   input wire                              reset_i,

   // code input
   input wire                              in_req_i,
   input var bitpack_pkg::pack_op_t        in_op_i,
   input wire [bitpack_pkg::CODE_W-1:0]    in_code_i,
   input wire [bitpack_pkg::LEN_W-1:0]     in_len_i,
   output logic                            in_ack_o,

   // word output
   output logic                            out_req_o,
   output logic [bitpack_pkg::WORD_W-1:0]  out_word_o,
   input wire                              out_ack_i,

   // status
   output logic [bitpack_pkg::CNT_W-1:0]   bit_count_o,
   output logic [bitpack_pkg::CNT_W-1:0]   word_count_o
);
   import bitpack_pkg::*;

   logic             word_busy;
   logic             word_load;
   logic             code_accept;
   logic [LEN_W-1:0] accept_len;

   bitfifo_if i_fifo_if ();

   pack_ctrl i_pack_ctrl (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .in_req_i     (in_req_i),
      .in_op_i      (in_op_i),
      .in_code_i    (in_code_i),
      .in_len_i     (in_len_i),
      .in_ack_o     (in_ack_o),
      .word_busy_i  (word_busy),
      .word_load_o  (word_load),
      .code_accept_o(code_accept),
      .accept_len_o (accept_len),
      .fifo_if      (i_fifo_if.ctrl)
   );

   bit_fifo i_bit_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .fifo_if(i_fifo_if.fifo)
   );

   // word taken straight from the fifo read data
   word_out_stage i_word_out_stage (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .word_load_i(word_load),
      .word_i     (i_fifo_if.rdata),
      .word_busy_o(word_busy),
      .out_req_o  (out_req_o),
      .out_word_o (out_word_o),
      .out_ack_i  (out_ack_i)
   );

   pack_counters i_pack_counters (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .code_accept_i(code_accept),
      .accept_len_i (accept_len),
      .word_load_i  (word_load),
      .bit_count_o  (bit_count_o),
      .word_count_o (word_count_o)
   );

endmodule

`default_nettype wire

//--- src/pack_counters.sv
`timescale 1ns/1ps
`default_nettype none

module pack_counters (
   input wire                            clk_i,
   input wire                            reset_i,
   input wire                            code_accept_i,
   input wire [bitpack_pkg::LEN_W-1:0]   accept_len_i,
   input wire                            word_load_i,
   output logic [bitpack_pkg::CNT_W-1:0] bit_count_o,
   output logic [bitpack_pkg::CNT_W-1:0] word_count_o
);
   import bitpack_pkg::*;

   logic [CNT_W-1:0] bit_count_q;
   logic [CNT_W-1:0] word_count_q;

   // both totals wrap
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         bit_count_q  <= '0;
         word_count_q <= '0;
      end else begin
         if (code_accept_i) begin
            bit_count_q <= bit_count_q + CNT_W'(accept_len_i);
         end
         if (word_load_i) begin
            word_count_q <= word_count_q + 1'b1;
         end
      end
   end

   assign bit_count_o  = bit_count_q;
   assign word_count_o = word_count_q;

endmodule

`default_nettype wire

//--- src/word_out_stage.sv
`timescale 1ns/1ps
`default_nettype none

module word_out_stage (
   input wire                            clk_i,
   input wire                            reset_i,
   input wire                            word_load_i,
   input wire [bitpack_pkg::WORD_W-1:0]  word_i,
   output logic                          word_busy_o,
   output logic                          out_req_o,
   output logic [bitpack_pkg::WORD_W-1:0] out_word_o,
   input wire                            out_ack_i
);
   import bitpack_pkg::*;

   logic [WORD_W-1:0] word_q;
   logic              req_q;
   logic              busy_q;

   // payload register
   always_ff @(posedge clk_i) begin
      if (word_load_i) begin
         word_q <= word_i;
      end
   end

   // busy spans from load until ack is low again
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         req_q  <= 1'b0;
         busy_q <= 1'b0;
      end else if (word_load_i) begin
         req_q  <= 1'b1;
         busy_q <= 1'b1;
      end else if (req_q && out_ack_i) begin
         req_q <= 1'b0;
      end else if (busy_q && !req_q && !out_ack_i) begin
         busy_q <= 1'b0;
      end
   end

   assign out_req_o   = req_q;
   assign out_word_o  = word_q;
   assign word_busy_o = busy_q;

endmodule

`default_nettype wire

//--- src/pack_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pack_ctrl (
   input wire                             clk_i,
   input wire                             reset_i,

   // producer side
   input wire                             in_req_i,
   input var bitpack_pkg::pack_op_t       in_op_i,
   input wire [bitpack_pkg::CODE_W-1:0]   in_code_i,
   input wire [bitpack_pkg::LEN_W-1:0]    in_len_i,
   output logic                           in_ack_o,

   // output stage and counters
   input wire                             word_busy_i,
   output logic                           word_load_o,
   output logic                           code_accept_o,
   output logic [bitpack_pkg::LEN_W-1:0]  accept_len_o,

   bitfifo_if.ctrl                        fifo_if
);
   import bitpack_pkg::*;

   ctrl_state_t      state_q;
   ctrl_state_t      state_nxt;

   logic             full_word;
   logic             has_room;
   logic [LEN_W-1:0] drain_width;

   assign full_word = (fifo_if.rlevel >= LVL_W'(WORD_W));
   assign has_room  = (fifo_if.wlevel >= LVL_W'(in_len_i));

   // full words first, otherwise the flush remainder
   assign drain_width = full_word ? LEN_W'(WORD_W) : fifo_if.rlevel[LEN_W-1:0];

   always_comb begin
      state_nxt = state_q;
      case (state_q)
         ST_IDLE: begin
            if (full_word) begin
               state_nxt = ST_DRAIN;
            end else if (in_req_i) begin
               if (in_op_i == OP_FLUSH) begin
                  // pad a partial word out before the ack
                  state_nxt = (fifo_if.rlevel != '0) ? ST_DRAIN : ST_ACK;
               end else if (has_room) begin
                  state_nxt = ST_WRITE;
               end
            end
         end
         ST_WRITE: begin
            state_nxt = ST_ACK;
         end
         ST_DRAIN: begin
            // hold here while the output stage is busy
            if (!word_busy_i) begin
               state_nxt = ST_IDLE;
            end
         end
         ST_ACK: begin
            state_nxt = ST_WAIT_REQ_LOW;
         end
         ST_WAIT_REQ_LOW: begin
            if (!in_req_i) begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   always_comb begin
      fifo_if.write  = 1'b0;
      fifo_if.read   = 1'b0;
      fifo_if.wwidth = in_len_i;
      fifo_if.wdata  = in_code_i;
      fifo_if.rwidth = drain_width;
      word_load_o    = 1'b0;
      code_accept_o  = 1'b0;
      accept_len_o   = in_len_i;
      if (state_q == ST_WRITE) begin
         fifo_if.write = 1'b1;
         code_accept_o = 1'b1;
      end
      if (state_q == ST_DRAIN && !word_busy_i) begin
         fifo_if.read = 1'b1;
         word_load_o  = 1'b1;
      end
   end

   // ack stays up until the producer lets go of req
   assign in_ack_o = (state_q == ST_ACK) || (state_q == ST_WAIT_REQ_LOW);

endmodule

`default_nettype wire

//--- src/bit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module bit_fifo (
   input wire      clk_i,
   input wire      reset_i,
   bitfifo_if.fifo fifo_if
);
   import bitpack_pkg::*;

   // oldest bit sits at the msb of the store
   logic [REG_W-1:0]  data_q;
   logic [REG_W-1:0]  data_nxt;
   logic [LVL_W-1:0]  rlevel_q;
   logic [LVL_W-1:0]  rlevel_nxt;

   logic [CODE_W-1:0] code_left;
   logic [REG_W-1:0]  code_ins;
   logic [WORD_W-1:0] top_word;

   // drop bits above the write width and left-align the code
   assign code_left = fifo_if.wdata << (CODE_W - fifo_if.wwidth);

   // new bits go right below the valid ones
   assign code_ins = {code_left, {(REG_W-CODE_W){1'b0}}} >> rlevel_q;

   assign top_word = data_q[REG_W-1 -: WORD_W];

   // read word keeps only rwidth bits with zeros below
   always_comb begin
      fifo_if.rdata = (top_word >> (WORD_W - fifo_if.rwidth)) << (WORD_W - fifo_if.rwidth);
   end

   assign fifo_if.rlevel = rlevel_q;
   assign fifo_if.wlevel = FULL_LEVEL - rlevel_q;

   // write wins over read
   always_comb begin
      data_nxt   = data_q;
      rlevel_nxt = rlevel_q;
      if (fifo_if.write) begin
         data_nxt   = data_q | code_ins;
         rlevel_nxt = rlevel_q + LVL_W'(fifo_if.wwidth);
      end else if (fifo_if.read) begin
         data_nxt   = data_q << fifo_if.rwidth;
         rlevel_nxt = rlevel_q - LVL_W'(fifo_if.rwidth);
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         data_q   <= '0;
         rlevel_q <= '0;
      end else begin
         data_q   <= data_nxt;
         rlevel_q <= rlevel_nxt;
      end
   end

endmodule

`default_nettype wire

//--- src/bitfifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bitfifo_if;
   import bitpack_pkg::*;

   // write side
   logic              write;
   logic [LEN_W-1:0]  wwidth;
   logic [CODE_W-1:0] wdata;
   logic [LVL_W-1:0]  wlevel;

   // read side
   logic              read;
   logic [LEN_W-1:0]  rwidth;
   logic [WORD_W-1:0] rdata;
   logic [LVL_W-1:0]  rlevel;

   modport ctrl (
      output write, read, wwidth, rwidth, wdata,
      input  rdata, rlevel, wlevel
   );

   modport fifo (
      input  write, read, wwidth, rwidth, wdata,
      output rdata, rlevel, wlevel
   );

endinterface

`default_nettype wire

//--- src/bitpack_pkg.sv
`default_nettype none

package bitpack_pkg;

   // code and word widths
   localparam int CODE_W = 16;
   localparam int LEN_W  = 5;
   localparam int WORD_W = 16;

   // bit store capacity and level width
   localparam int REG_W = 32;
   localparam int LVL_W = 6;
   localparam logic [LVL_W-1:0] FULL_LEVEL = 6'd32;

   // status counters
   localparam int CNT_W = 16;

   typedef enum logic [0:0] {
      OP_PUSH  = 1'b0,
      OP_FLUSH = 1'b1
   } pack_op_t;

   typedef enum logic [2:0] {
      ST_IDLE         = 3'd0,
      ST_WRITE        = 3'd1,
      ST_DRAIN        = 3'd2,
      ST_ACK          = 3'd3,
      ST_WAIT_REQ_LOW = 3'd4
   } ctrl_state_t;

endpackage

`default_nettype wire
